// ==== verilog/rv32_config.svh ====
`ifndef RV32_CONFIG_SVH
`define RV32_CONFIG_SVH

// Data word width
`define RV32_XLEN 32

// Architectural registers
`define RV32_NUM_REGS 32
`define RV32_REG_W 5

`endif

// ==== verilog/rv32_types.sv ====
`include "rv32_config.svh"

package rv32_types;

    typedef logic [`RV32_XLEN-1:0] rv32_word;

    // Major opcodes handled by the slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // One instruction word, seen through the format named by its opcode
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
    } rv32_instr_u;

    typedef enum logic [2:0] {
        ALU_IN_REG_1, ALU_IN_REG_2, ALU_IN_PC, ALU_IN_IMM, ALU_IN_ZERO
    } alu_in_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_t;

    typedef enum logic [2:0] {
        NONE, EQ, NE, LT, GE, LTU, GEU, ALWAYS
    } branch_op_t;

    // Encoded as funct3[1:0]
    typedef enum logic [1:0] {
        MUL, MULH, MULHSU, MULHU
    } mul_op_t;

    typedef enum logic [1:0] {
        WB_PC4, WB_INT_ALU, WB_MUL_UNIT
    } wb_src_t;

    typedef enum logic [1:0] {
        BYPASS_NONE, BYPASS_EXEC_BUFF, BYPASS_RESULT_BUFF
    } bypass_src_t;

    typedef struct packed {
        alu_in_t     alu_in_1;
        alu_in_t     alu_in_2;
        alu_op_t     alu_op;
        branch_op_t  branch_op;
        wb_src_t     wb_src;
        logic        reg_write;
        bypass_src_t bypass_rs1;
        bypass_src_t bypass_rs2;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        rv32_word    pc;
        rv32_instr_u instr;
        rv32_word    imm;
        rv32_word    rs1_data;
        rv32_word    rs2_data;
        ctrl_t       ctrl;
    } decode_exec_buffer_t;

    typedef struct packed {
        logic                  valid;
        rv32_word              pc;
        logic [`RV32_REG_W-1:0] rd;
        logic                  reg_write;
        rv32_word              result;
        logic                  jump;
        rv32_word              jump_addr;
    } exec_mem_buffer_t;

    typedef struct packed {
        rv32_word              pc;
        logic [`RV32_REG_W-1:0] rd;
        logic                  reg_write;
        rv32_word              rd_value;
        logic                  jump;
        rv32_word              jump_addr;
    } retire_rec_t;

    // Control word that changes no state
    function automatic ctrl_t create_bubble_ctrl();
        ctrl_t ctrl;
        ctrl = '0;
        ctrl.alu_op = ADD;
        ctrl.branch_op = NONE;
        ctrl.wb_src = WB_INT_ALU;
        ctrl.reg_write = 1'b0;
        return ctrl;
    endfunction

endpackage

// ==== verilog/rv32_regfile.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_regfile (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`RV32_REG_W-1:0] rs1_addr,
    input  logic [`RV32_REG_W-1:0] rs2_addr,
    output rv32_types::rv32_word   rs1_data,
    output rv32_types::rv32_word   rs2_data,
    input  logic                   wr_en,
    input  logic [`RV32_REG_W-1:0] wr_addr,
    input  rv32_types::rv32_word   wr_data
);
    import rv32_types::*;

    rv32_word regs [`RV32_NUM_REGS];

    // x0 is cleared by reset and never written
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int idx = 0; idx < `RV32_NUM_REGS; idx++) begin
                regs[idx] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== verilog/rv32_decode_stage.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_decode_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            in_req,
    output logic                            in_ack,
    input  rv32_types::rv32_instr_u         in_instr,
    input  rv32_types::rv32_word            in_pc,
    output logic [`RV32_REG_W-1:0]          rs1_addr,
    output logic [`RV32_REG_W-1:0]          rs2_addr,
    input  rv32_types::rv32_word            rs1_data,
    input  rv32_types::rv32_word            rs2_data,
    input  rv32_types::exec_mem_buffer_t    exec_buff,
    input  rv32_types::exec_mem_buffer_t    result_buff,
    input  logic                            stall,
    output rv32_types::decode_exec_buffer_t decode_exec_buff
);
    import rv32_types::*;

    function automatic alu_op_t alu_op_from(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    decode_exec_buffer_t next_buff;
    logic capture;
    logic de_wr, ex_wr, rb_wr;

    assign capture = in_req && !in_ack && !stall;
    assign rs1_addr = in_instr.r.rs1;
    assign rs2_addr = in_instr.r.rs2;

    // Writers ahead of this instruction, youngest first
    assign de_wr = decode_exec_buff.valid && decode_exec_buff.ctrl.reg_write &&
                   decode_exec_buff.instr.r.rd != '0;
    assign ex_wr = exec_buff.valid && exec_buff.reg_write && exec_buff.rd != '0;
    assign rb_wr = result_buff.valid && result_buff.reg_write && result_buff.rd != '0;

    always_comb begin
        next_buff = '0;
        next_buff.valid = capture;
        next_buff.pc = in_pc;
        next_buff.instr = in_instr;
        next_buff.ctrl = create_bubble_ctrl();
        next_buff.ctrl.alu_in_1 = ALU_IN_PC;
        next_buff.ctrl.alu_in_2 = ALU_IN_IMM;
        next_buff.ctrl.reg_write = 1'b1;
        case (in_instr.r.opcode)
            OPC_OP: begin
                next_buff.ctrl.alu_in_1 = ALU_IN_REG_1;
                next_buff.ctrl.alu_in_2 = ALU_IN_REG_2;
                next_buff.ctrl.alu_op = alu_op_from(in_instr.r.funct3, in_instr.r.funct7[5]);
                if (in_instr.r.funct7[0]) begin
                    next_buff.ctrl.wb_src = WB_MUL_UNIT;
                end
            end
            OPC_OP_IMM: begin
                next_buff.ctrl.alu_in_1 = ALU_IN_REG_1;
                next_buff.ctrl.alu_op = alu_op_from(in_instr.i.funct3,
                    in_instr.i.funct3 == 3'b101 && in_instr.i.imm12[10]);
                next_buff.imm = {{20{in_instr.i.imm12[11]}}, in_instr.i.imm12};
            end
            OPC_LUI: begin
                next_buff.ctrl.alu_in_1 = ALU_IN_ZERO;
                next_buff.imm = {in_instr.u.imm20, 12'b0};
            end
            OPC_AUIPC: next_buff.imm = {in_instr.u.imm20, 12'b0};
            OPC_JAL: begin
                next_buff.ctrl.branch_op = ALWAYS;
                next_buff.ctrl.wb_src = WB_PC4;
                next_buff.imm = {{12{in_instr.u.imm20[19]}}, in_instr.u.imm20[7:0],
                                 in_instr.u.imm20[8], in_instr.u.imm20[18:9], 1'b0};
            end
            OPC_JALR: begin
                next_buff.ctrl.alu_in_1 = ALU_IN_REG_1;
                next_buff.ctrl.branch_op = ALWAYS;
                next_buff.ctrl.wb_src = WB_PC4;
                next_buff.imm = {{20{in_instr.i.imm12[11]}}, in_instr.i.imm12};
            end
            OPC_BRANCH: begin
                next_buff.ctrl.reg_write = 1'b0;
                next_buff.imm = {{20{in_instr.b.imm12}}, in_instr.b.imm11,
                                 in_instr.b.imm10_5, in_instr.b.imm4_1, 1'b0};
                case (in_instr.b.funct3)
                    3'b000:  next_buff.ctrl.branch_op = EQ;
                    3'b001:  next_buff.ctrl.branch_op = NE;
                    3'b100:  next_buff.ctrl.branch_op = LT;
                    3'b101:  next_buff.ctrl.branch_op = GE;
                    3'b110:  next_buff.ctrl.branch_op = LTU;
                    default: next_buff.ctrl.branch_op = GEU;
                endcase
            end
            // Unsupported, retires without a register write
            default: next_buff.ctrl = create_bubble_ctrl();
        endcase

        // A writer one slot ahead reaches exec_mem, two ahead the result register
        if (de_wr && decode_exec_buff.instr.r.rd == in_instr.r.rs1) begin
            next_buff.ctrl.bypass_rs1 = BYPASS_EXEC_BUFF;
        end else if (ex_wr && exec_buff.rd == in_instr.r.rs1) begin
            next_buff.ctrl.bypass_rs1 = BYPASS_RESULT_BUFF;
        end
        if (de_wr && decode_exec_buff.instr.r.rd == in_instr.r.rs2) begin
            next_buff.ctrl.bypass_rs2 = BYPASS_EXEC_BUFF;
        end else if (ex_wr && exec_buff.rd == in_instr.r.rs2) begin
            next_buff.ctrl.bypass_rs2 = BYPASS_RESULT_BUFF;
        end

        // Held record may retire on this edge, so take its value now
        next_buff.rs1_data = (rb_wr && result_buff.rd == in_instr.r.rs1) ?
                             result_buff.result : rs1_data;
        next_buff.rs2_data = (rb_wr && result_buff.rd == in_instr.r.rs2) ?
                             result_buff.result : rs2_data;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            in_ack <= 1'b0;
            decode_exec_buff <= '0;
        end else begin
            if (capture) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;
            end
            if (!stall) begin
                decode_exec_buff <= next_buff;
            end
        end
    end

endmodule

// ==== verilog/rv32_exec_stage.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_exec_stage (
    input  logic                            clk,
    input  logic                            resetn,
    input  rv32_types::decode_exec_buffer_t decode_exec_buff,
    input  logic                            stall,
    input  rv32_types::exec_mem_buffer_t    result_buff,
    output rv32_types::exec_mem_buffer_t    exec_mem_buff
);
    import rv32_types::*;

    function automatic rv32_word operand(input alu_in_t sel, input rv32_word reg1,
                                         input rv32_word reg2, input rv32_word pc,
                                         input rv32_word imm);
        case (sel)
            ALU_IN_REG_1: return reg1;
            ALU_IN_REG_2: return reg2;
            ALU_IN_PC:    return pc;
            ALU_IN_IMM:   return imm;
            default:      return '0;
        endcase
    endfunction

    ctrl_t ctrl;
    rv32_word op1, op2, alu_a, alu_b, alu_result, mul_result;
    mul_op_t mul_op;
    logic signed [`RV32_XLEN:0] mul_a, mul_b;
    logic signed [2*`RV32_XLEN+1:0] product;
    logic taken, is_jalr;
    exec_mem_buffer_t next_buff;

    assign ctrl = decode_exec_buff.ctrl;

    // Bypass
    always_comb begin
        case (ctrl.bypass_rs1)
            BYPASS_EXEC_BUFF:   op1 = exec_mem_buff.result;
            BYPASS_RESULT_BUFF: op1 = result_buff.result;
            default:            op1 = decode_exec_buff.rs1_data;
        endcase
        case (ctrl.bypass_rs2)
            BYPASS_EXEC_BUFF:   op2 = exec_mem_buff.result;
            BYPASS_RESULT_BUFF: op2 = result_buff.result;
            default:            op2 = decode_exec_buff.rs2_data;
        endcase
    end

    assign alu_a = operand(ctrl.alu_in_1, op1, op2, decode_exec_buff.pc, decode_exec_buff.imm);
    assign alu_b = operand(ctrl.alu_in_2, op1, op2, decode_exec_buff.pc, decode_exec_buff.imm);

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_result = alu_a + alu_b;
            SUB:     alu_result = alu_a - alu_b;
            SLL:     alu_result = alu_a << alu_b[4:0];
            SLT:     alu_result = {{(`RV32_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            SLTU:    alu_result = {{(`RV32_XLEN-1){1'b0}}, alu_a < alu_b};
            XOR:     alu_result = alu_a ^ alu_b;
            SRL:     alu_result = alu_a >> alu_b[4:0];
            SRA:     alu_result = $signed(alu_a) >>> alu_b[4:0];
            OR:      alu_result = alu_a | alu_b;
            default: alu_result = alu_a & alu_b;
        endcase
    end

    // Extra top bit carries the sign only for signed operands
    assign mul_op = mul_op_t'(decode_exec_buff.instr.r.funct3[1:0]);
    assign mul_a = {(mul_op != MULHU) & op1[`RV32_XLEN-1], op1};
    assign mul_b = {(mul_op == MUL || mul_op == MULH) & op2[`RV32_XLEN-1], op2};
    assign product = mul_a * mul_b;
    assign mul_result = (mul_op == MUL) ? product[`RV32_XLEN-1:0] :
                                          product[2*`RV32_XLEN-1:`RV32_XLEN];

    always_comb begin
        case (ctrl.branch_op)
            EQ:      taken = op1 == op2;
            NE:      taken = op1 != op2;
            LT:      taken = $signed(op1) < $signed(op2);
            GE:      taken = $signed(op1) >= $signed(op2);
            LTU:     taken = op1 < op2;
            GEU:     taken = op1 >= op2;
            ALWAYS:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jalr = decode_exec_buff.instr.r.opcode == OPC_JALR;

    always_comb begin
        next_buff.valid = decode_exec_buff.valid;
        next_buff.pc = decode_exec_buff.pc;
        next_buff.rd = decode_exec_buff.instr.r.rd;
        next_buff.reg_write = ctrl.reg_write;
        case (ctrl.wb_src)
            WB_PC4:      next_buff.result = decode_exec_buff.pc + 4;
            WB_MUL_UNIT: next_buff.result = mul_result;
            default:     next_buff.result = alu_result;
        endcase
        next_buff.jump = taken;
        // Target is the ALU sum, reported for branches even when not taken
        if (ctrl.branch_op == NONE) begin
            next_buff.jump_addr = '0;
        end else begin
            next_buff.jump_addr = {alu_result[`RV32_XLEN-1:1], alu_result[0] & ~is_jalr};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_mem_buff <= '0;
        end else if (!stall) begin
            exec_mem_buff <= next_buff;
        end
    end

endmodule

// ==== verilog/rv32_result_stage.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_result_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  rv32_types::exec_mem_buffer_t exec_mem_buff,
    output logic                         out_req,
    input  logic                         out_ack,
    output rv32_types::retire_rec_t      out_rec,
    output rv32_types::exec_mem_buffer_t result_buff,
    output logic                         stall,
    output logic                         wr_en,
    output logic [`RV32_REG_W-1:0]       wr_addr,
    output rv32_types::rv32_word         wr_data
);
    import rv32_types::*;

    logic retire;
    logic ack_wait, ack_wait_next, valid_next;

    assign retire = out_req && out_ack;
    assign stall = result_buff.valid && !retire;

    // Hold off the next request until the last ack has been seen low
    assign ack_wait_next = retire || (ack_wait && out_ack);
    assign valid_next = stall ? result_buff.valid : exec_mem_buff.valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            result_buff <= '0;
            out_req <= 1'b0;
            ack_wait <= 1'b0;
        end else begin
            if (!stall) begin
                result_buff <= exec_mem_buff;
            end
            ack_wait <= ack_wait_next;
            out_req <= valid_next && !ack_wait_next;
        end
    end

    assign out_rec.pc = result_buff.pc;
    assign out_rec.rd = result_buff.rd;
    assign out_rec.reg_write = result_buff.reg_write;
    assign out_rec.rd_value = result_buff.result;
    assign out_rec.jump = result_buff.jump;
    assign out_rec.jump_addr = result_buff.jump_addr;

    // Register file is written on the retire edge
    assign wr_en = retire && result_buff.reg_write;
    assign wr_addr = result_buff.rd;
    assign wr_data = result_buff.result;

endmodule

// ==== verilog/rv32_core_slice.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module rv32_core_slice (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_req,
    output logic                    in_ack,
    input  rv32_types::rv32_instr_u in_instr,
    input  rv32_types::rv32_word    in_pc,
    output logic                    out_req,
    input  logic                    out_ack,
    output rv32_types::retire_rec_t out_rec
);
    import rv32_types::*;

    logic [`RV32_REG_W-1:0] rs1_addr, rs2_addr, wr_addr;
    rv32_word rs1_data, rs2_data, wr_data;
    logic wr_en, stall;
    decode_exec_buffer_t decode_exec_buff;
    exec_mem_buffer_t exec_mem_buff, result_buff;

    rv32_regfile u_regfile (
        .clk(clk), .resetn(resetn),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    rv32_decode_stage u_decode (
        .clk(clk), .resetn(resetn),
        .in_req(in_req), .in_ack(in_ack),
        .in_instr(in_instr), .in_pc(in_pc),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .exec_buff(exec_mem_buff), .result_buff(result_buff),
        .stall(stall),
        .decode_exec_buff(decode_exec_buff)
    );

    rv32_exec_stage u_exec (
        .clk(clk), .resetn(resetn),
        .decode_exec_buff(decode_exec_buff),
        .stall(stall),
        .result_buff(result_buff),
        .exec_mem_buff(exec_mem_buff)
    );

    rv32_result_stage u_result (
        .clk(clk), .resetn(resetn),
        .exec_mem_buff(exec_mem_buff),
        .out_req(out_req), .out_ack(out_ack), .out_rec(out_rec),
        .result_buff(result_buff),
        .stall(stall),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

// ==== tb/tb_rv32_core_slice.sv ====
`timescale 1ns/100ps
`include "rv32_config.svh"

module tb_rv32_core_slice;
    import rv32_types::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int MAX_ACK_DELAY = 5;
    localparam int IDLE_CYCLES = 20;

    // One line of the program file
    typedef struct packed {
        rv32_word               instr;
        rv32_word               pc;
        logic [`RV32_REG_W-1:0] rd;
        rv32_word               rd_value;
        logic                   reg_write;
        logic                   jump;
        rv32_word               jump_addr;
    } prog_line_t;

    logic        clk;
    logic        resetn;
    logic        in_req;
    logic        in_ack;
    rv32_instr_u in_instr;
    rv32_word    in_pc;
    logic        out_req;
    logic        out_ack;
    retire_rec_t out_rec;

    prog_line_t  program_lines[$];
    int          retired;
    int unsigned seed_state;

    rv32_core_slice uut (
        .clk(clk), .resetn(resetn),
        .in_req(in_req), .in_ack(in_ack),
        .in_instr(in_instr), .in_pc(in_pc),
        .out_req(out_req), .out_ack(out_ack), .out_rec(out_rec)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Every edge with out_req and out_ack both high is one retire
    always @(posedge clk) begin
        if (out_req && out_ack) begin
            retired++;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s: expected %08h, actual %08h",
                                      name, expected, actual));
        end
    endtask

    // Drive point after the next rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_program();
        int fd;
        int fields;
        logic [8*160-1:0] text_line;
        logic [31:0] c_instr, c_pc, c_rd, c_value, c_wr, c_jump, c_target;
        prog_line_t entry;
        fd = $fopen("tb/rv32_program_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the program file tb/rv32_program_input.txt");
        end
        while ($fgets(text_line, fd) != 0) begin
            fields = $sscanf(text_line, "%h %h %h %h %h %h %h", c_instr, c_pc, c_rd,
                             c_value, c_wr, c_jump, c_target);
            // Comment and blank lines scan no field
            if (fields == 7) begin
                entry.instr = c_instr;
                entry.pc = c_pc;
                entry.rd = c_rd[`RV32_REG_W-1:0];
                entry.rd_value = c_value;
                entry.reg_write = c_wr[0];
                entry.jump = c_jump[0];
                entry.jump_addr = c_target;
                program_lines.push_back(entry);
            end else if (fields > 0) begin
                stop_with_error("the program file holds a line with missing columns");
            end
        end
        $fclose(fd);
        if (program_lines.size() == 0) begin
            stop_with_error("the program file holds no instruction");
        end
    endtask

    task automatic drive_program();
        int waited;
        for (int idx = 0; idx < program_lines.size(); idx++) begin
            in_instr = program_lines[idx].instr;
            in_pc = program_lines[idx].pc;
            in_req = 1'b1;
            waited = 0;
            while (!in_ack) begin
                step();
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    stop_with_error($sformatf("in_ack never rose for the instruction at pc %08h",
                                              program_lines[idx].pc));
                end
            end
            in_req = 1'b0;
            waited = 0;
            while (in_ack) begin
                step();
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    stop_with_error("in_ack stayed high after in_req was dropped");
                end
            end
        end
    endtask

    task automatic collect_records();
        int waited;
        int delay;
        string name;
        prog_line_t expected_line;
        for (int idx = 0; idx < program_lines.size(); idx++) begin
            expected_line = program_lines[idx];
            waited = 0;
            while (!out_req) begin
                step();
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    stop_with_error($sformatf("out_req never rose for record %0d", idx));
                end
            end
            name = $sformatf("record %0d pc %08h", idx, expected_line.pc);
            check_value({name, " pc"}, expected_line.pc, out_rec.pc);
            check_value({name, " reg_write"}, expected_line.reg_write, out_rec.reg_write);
            // rd fields only mean something for a writing record
            if (expected_line.reg_write) begin
                check_value({name, " rd"}, expected_line.rd, out_rec.rd);
                check_value({name, " rd_value"}, expected_line.rd_value, out_rec.rd_value);
            end
            check_value({name, " jump"}, expected_line.jump, out_rec.jump);
            check_value({name, " jump_addr"}, expected_line.jump_addr, out_rec.jump_addr);

            // Random back-pressure before the acknowledge
            delay = $urandom % MAX_ACK_DELAY;
            repeat (delay) step();
            out_ack = 1'b1;
            waited = 0;
            while (out_req) begin
                step();
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    stop_with_error("out_req stayed high after out_ack was raised");
                end
            end
            out_ack = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        in_req = 1'b0;
        in_instr = '0;
        in_pc = '0;
        out_ack = 1'b0;
        retired = 0;
        seed_state = 32'h86d7;
        seed_state = $urandom(seed_state);
        load_program();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b1;

        fork
            drive_program();
            collect_records();
        join

        // Nothing may retire twice
        repeat (IDLE_CYCLES) begin
            step();
            if (out_req) begin
                stop_with_error("out_req rose again after the last record retired");
            end
        end

        if (retired != program_lines.size()) begin
            stop_with_error($sformatf("%0d records retired for %0d instructions sent",
                                      retired, program_lines.size()));
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== tb/rv32_program_input.txt ====
# instr    pc       rd rd_value wr jump jump_addr  (all hex)
# rd and rd_value are checked only on lines with wr set
12300093 00000100 01 00000123 1 0 00000000
ff900113 00000104 02 fffffff9 1 0 00000000
123451b7 00000108 03 12345000 1 0 00000000
00001217 0000010c 04 0000110c 1 0 00000000
002082b3 00000110 05 0000011c 1 0 00000000
40128333 00000114 06 fffffff9 1 0 00000000
005343b3 00000118 07 fffffee5 1 0 00000000
40115413 0000011c 08 fffffffc 1 0 00000000
0043d493 00000120 09 0fffffee 1 0 00000000
00112533 00000124 0a 00000001 1 0 00000000
003566b3 00000128 0d 12345001 1 0 00000000
023107b3 0000012c 0f 8091d000 1 0 00000000
02311833 00000130 10 ffffffff 1 0 00000000
022128b3 00000134 11 fffffff9 1 0 00000000
02213933 00000138 12 fffffff2 1 0 00000000
00108863 0000013c 00 00000000 0 1 0000014c
00109463 00000140 00 00000000 0 0 00000148
fe1148e3 00000144 00 00000000 0 1 00000134
00115a63 00000148 00 00000000 0 0 0000015c
00116663 0000014c 00 00000000 0 0 00000158
fe117ee3 00000150 00 00000000 0 1 0000014c
04000a6f 00000154 14 00000158 1 1 00000194
01008ae7 00000158 15 0000015c 1 1 00000132
00508013 0000015c 00 00000128 1 0 00000000
00100b33 00000160 16 00000123 1 0 00000000

// ==== all.f ====
+incdir+verilog
verilog/rv32_types.sv
verilog/rv32_regfile.sv
verilog/rv32_decode_stage.sv
verilog/rv32_exec_stage.sv
verilog/rv32_result_stage.sv
verilog/rv32_core_slice.sv
tb/tb_rv32_core_slice.sv

// ==== Bender.yml ====
package:
  name: rv32_core_slice

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv32_types.sv
      - verilog/rv32_regfile.sv
      - verilog/rv32_decode_stage.sv
      - verilog/rv32_exec_stage.sv
      - verilog/rv32_result_stage.sv
      - verilog/rv32_core_slice.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - tb/tb_rv32_core_slice.sv
